//--- axil_mem.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/mem_msg_pkg.sv
verilog/axil_fifo_client.sv
verilog/axil_mem_client.sv
verilog/mem_responder.sv
verilog/axil_mem_top.sv
bench/tb_clock_gen.sv
bench/axil_mem_assertions.sv
bench/axil_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the axil_mem testbench with Verilator.
# The exit status is the simulator's: non-zero when the bench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f axil_mem.f \
  --top-module axil_mem_tb -o axil_mem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/axil_mem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- bench/axil_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module axil_mem_tb;

  localparam int N_FULL = 8;
  localparam int N_PART = 12;
  localparam int N_ODD  = 6;
  localparam int N_BP   = 6;
  localparam int N_PRIO = 4;
  // Each loop issues one write and one read
  localparam int TOTAL_TXNS = 2 * (N_FULL + N_PART + N_ODD + N_BP + N_PRIO);

  // Contiguous but misaligned, split, and empty masks
  localparam logic [7:0] ODD_MASKS [N_ODD] = '{8'h00, 8'h05, 8'h81, 8'h06, 8'h3C, 8'h0E};

  logic                 clk;
  logic                 rst;
  mem_msg_pkg::lce_id_t lce_id;
  mem_msg_pkg::did_t    did;
  axil_pkg::axil_addr_t awaddr;
  axil_pkg::axil_addr_t araddr;
  logic [2:0]           awprot;
  logic [2:0]           arprot;
  axil_pkg::axil_data_t wdata;
  axil_pkg::axil_strb_t wstrb;
  axil_pkg::axil_data_t rdata;
  axil_pkg::axil_resp_t bresp;
  axil_pkg::axil_resp_t rresp;
  logic                 awvalid;
  logic                 awready;
  logic                 wvalid;
  logic                 wready;
  logic                 bvalid;
  logic                 bready;
  logic                 arvalid;
  logic                 arready;
  logic                 rvalid;
  logic                 rready;

  // Byte-level reference memory
  logic [7:0] ref_mem [`MEM_WORDS*`AXIL_MASK_W];

  tb_clock_gen u_clk (
    .clk_o (clk)
  );

  axil_mem_top u_dut (
    .clk_i            (clk),
    .rst_i            (rst),
    .lce_id_i         (lce_id),
    .did_i            (did),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awprot_i  (awprot),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arprot_i  (arprot),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  bind axil_mem_top axil_mem_assertions u_assertions (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awvalid_i (s_axil_awvalid_i),
    .awready_i (s_axil_awready_o),
    .wvalid_i  (s_axil_wvalid_i),
    .wready_i  (s_axil_wready_o),
    .arvalid_i (s_axil_arvalid_i),
    .arready_i (s_axil_arready_o),
    .bresp_i   (s_axil_bresp_o),
    .bvalid_i  (s_axil_bvalid_o),
    .bready_i  (s_axil_bready_i),
    .rdata_i   (s_axil_rdata_o),
    .rresp_i   (s_axil_rresp_o),
    .rvalid_i  (s_axil_rvalid_o),
    .rready_i  (s_axil_rready_i)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("error %s expected %h actual %h", name, exp, act);
      abort_run("response value mismatch");
    end
  endtask

  // Aligned 1, 2 or 4 byte groups keep their lanes and all else is a full word
  function automatic logic [7:0] lanes_for_mask(input logic [7:0] strb);
    int n;
    int low;
    n = $countones(strb);
    low = 0;
    while (low < 8 && !strb[low]) begin
      low++;
    end
    if ((n == 1 || n == 2 || n == 4) && (low % n == 0)
        && (strb == 8'(((1 << n) - 1) << low))) begin
      return strb;
    end
    return 8'hFF;
  endfunction

  task automatic model_write(input int idx, input axil_pkg::axil_data_t data,
                             input axil_pkg::axil_strb_t strb);
    logic [7:0] lanes;
    lanes = lanes_for_mask(strb);
    for (int b = 0; b < 8; b++) begin
      if (lanes[b]) begin
        ref_mem[idx*8 + b] = data[8*b +: 8];
      end
    end
  endtask

  function automatic axil_pkg::axil_data_t model_word(input int idx);
    axil_pkg::axil_data_t word;
    for (int b = 0; b < 8; b++) begin
      word[8*b +: 8] = ref_mem[idx*8 + b];
    end
    return word;
  endfunction

  // Returns 5 ns after the edge that took the request
  task automatic wait_accept(input logic is_write);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = is_write ? (awready && wready) : arready;
      @(posedge clk);
      #5;
    end
  endtask

  // Under stress the ready toggles and a stray request waits on the other channel
  task automatic wait_resp(input logic is_write, input logic stress,
                           output axil_pkg::axil_data_t data);
    logic taken;
    taken = 1'b0;
    data = '0;
    if (stress) begin
      araddr  = 16'h0008;
      arvalid = is_write;
      awvalid = !is_write;
      wvalid  = !is_write;
    end
    while (!taken) begin
      bready = stress ? ($urandom % 3 == 0) : 1'b1;
      rready = stress ? ($urandom % 3 == 0) : 1'b1;
      @(negedge clk);
      if (is_write) begin
        assert (!(arvalid && arready)) else begin
          abort_run("read accepted before the write response completed");
        end
      end
      taken = is_write ? (bvalid && bready) : (rvalid && rready);
      data = rdata;
      @(posedge clk);
      #5;
    end
    if (stress) begin
      arvalid = 1'b0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
    end
    bready = 1'b1;
    rready = 1'b1;
  endtask

  task automatic axi_write(input int idx, input axil_pkg::axil_data_t data,
                           input axil_pkg::axil_strb_t strb, input logic stress);
    axil_pkg::axil_data_t resp_data;
    awaddr  = 16'(idx * 8);
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_accept(1'b1);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    model_write(idx, data, strb);
    wait_resp(1'b1, stress, resp_data);
  endtask

  task automatic read_check(input string name, input int idx, input logic stress);
    axil_pkg::axil_data_t got;
    araddr  = 16'(idx * 8);
    arvalid = 1'b1;
    wait_accept(1'b0);
    arvalid = 1'b0;
    wait_resp(1'b0, stress, got);
    check_value(name, model_word(idx), got);
  endtask

  // Write and read raised in the same cycle
  task automatic write_read_same_cycle(input int idx, input axil_pkg::axil_data_t data,
                                       input axil_pkg::axil_strb_t strb);
    axil_pkg::axil_data_t got;
    awaddr  = 16'(idx * 8);
    wdata   = data;
    wstrb   = strb;
    araddr  = 16'(idx * 8);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    wait_accept(1'b1);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    model_write(idx, data, strb);
    wait_resp(1'b1, 1'b0, got);
    wait_accept(1'b0);
    arvalid = 1'b0;
    wait_resp(1'b0, 1'b0, got);
    check_value("write_priority", model_word(idx), got);
  endtask

  always @(negedge clk) begin
    if (u_dut.u_assertions.fail_count != 0) begin
      abort_run("protocol assertion failed");
    end
  end

  initial begin
    repeat (200 * TOTAL_TXNS + 10) @(posedge clk);
    abort_run("watchdog timeout, the DUT stopped responding");
  end

  initial begin
    int                   idx;
    int                   n;
    int                   off;
    axil_pkg::axil_data_t data;
    axil_pkg::axil_strb_t strb;

    void'($urandom(67));
    rst     = 1'b1;
    lce_id  = 4'h5;
    did     = 3'h2;
    awaddr  = '0;
    araddr  = '0;
    awprot  = 3'b000;
    arprot  = 3'b000;
    wdata   = '0;
    wstrb   = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b1;
    rready  = 1'b1;
    for (int i = 0; i < `MEM_WORDS*`AXIL_MASK_W; i++) begin
      ref_mem[i] = 8'h00;
    end

    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;

    // Idle outputs stay quiet with no request
    repeat (3) begin
      @(negedge clk);
      check_value("reset", 64'd0, {59'd0, awready, wready, arready, bvalid, rvalid});
    end
    @(posedge clk);
    #5;

    for (int i = 0; i < N_FULL; i++) begin
      idx = $urandom % `MEM_WORDS;
      data = {$urandom, $urandom};
      axi_write(idx, data, 8'hFF, 1'b0);
      read_check("full_word", idx, 1'b0);
    end

    for (int i = 0; i < N_PART; i++) begin
      idx = $urandom % `MEM_WORDS;
      n = 1 << ($urandom % 3);
      off = ($urandom % (8 / n)) * n;
      strb = 8'(((1 << n) - 1) << off);
      data = {$urandom, $urandom};
      axi_write(idx, data, strb, 1'b0);
      read_check("partial", idx, 1'b0);
    end

    for (int i = 0; i < N_ODD; i++) begin
      idx = $urandom % `MEM_WORDS;
      data = {$urandom, $urandom};
      axi_write(idx, data, ODD_MASKS[i], 1'b0);
      read_check("odd_mask", idx, 1'b0);
    end

    for (int i = 0; i < N_BP; i++) begin
      idx = $urandom % `MEM_WORDS;
      data = {$urandom, $urandom};
      axi_write(idx, data, 8'hFF, 1'b1);
      read_check("back_pressure", idx, 1'b1);
    end

    for (int i = 0; i < N_PRIO; i++) begin
      idx = $urandom % `MEM_WORDS;
      data = {$urandom, $urandom};
      write_read_same_cycle(idx, data, 8'hFF);
    end

    repeat (2) @(posedge clk);
    if (u_dut.u_assertions.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- bench/axil_mem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_assertions (
  input wire        clk_i,
  input wire        rst_i,
  input wire        awvalid_i,
  input wire        awready_i,
  input wire        wvalid_i,
  input wire        wready_i,
  input wire        arvalid_i,
  input wire        arready_i,
  input wire [1:0]  bresp_i,
  input wire        bvalid_i,
  input wire        bready_i,
  input wire [63:0] rdata_i,
  input wire [1:0]  rresp_i,
  input wire        rvalid_i,
  input wire        rready_i
);

  // Failed assertion count
  int fail_count = 0;

  // Write response holds until bready
  assert property (@(posedge clk_i) disable iff (rst_i)
                   bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      fail_count++;
      $error("bvalid dropped or bresp changed while bready was low");
    end

  // Read response holds until rready
  assert property (@(posedge clk_i) disable iff (rst_i)
                   rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      fail_count++;
      $error("rvalid dropped or read data changed while rready was low");
    end

  assert property (@(posedge clk_i) disable iff (rst_i)
                   !(bvalid_i && bresp_i != 2'b00) && !(rvalid_i && rresp_i != 2'b00))
    else begin
      fail_count++;
      $error("response code other than OKAY");
    end

  // Nothing new is taken while a response waits
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (bvalid_i || rvalid_i) |->
                   !(awvalid_i && awready_i) && !(wvalid_i && wready_i)
                   && !(arvalid_i && arready_i))
    else begin
      fail_count++;
      $error("request accepted while a response was pending");
    end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- verilog/axil_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_top (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire mem_msg_pkg::lce_id_t lce_id_i,
  input  wire mem_msg_pkg::did_t    did_i,

  input  wire axil_pkg::axil_addr_t s_axil_awaddr_i,
  input  wire [2:0]                 s_axil_awprot_i,
  input  wire                       s_axil_awvalid_i,
  output logic                      s_axil_awready_o,
  input  wire axil_pkg::axil_data_t s_axil_wdata_i,
  input  wire axil_pkg::axil_strb_t s_axil_wstrb_i,
  input  wire                       s_axil_wvalid_i,
  output logic                      s_axil_wready_o,
  output axil_pkg::axil_resp_t      s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  wire                       s_axil_bready_i,
  input  wire axil_pkg::axil_addr_t s_axil_araddr_i,
  input  wire [2:0]                 s_axil_arprot_i,
  input  wire                       s_axil_arvalid_i,
  output logic                      s_axil_arready_o,
  output axil_pkg::axil_data_t      s_axil_rdata_o,
  output axil_pkg::axil_resp_t      s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  wire                       s_axil_rready_i
);

  // Message channels between bridge and memory
  logic [mem_msg_pkg::MSG_FWD_HDR_W-1:0] mem_fwd_header;
  mem_msg_pkg::msg_data_t                mem_fwd_data;
  logic                                  mem_fwd_v;
  logic                                  mem_fwd_ready_and;
  logic [mem_msg_pkg::MSG_FWD_HDR_W-1:0] mem_rev_header;
  mem_msg_pkg::msg_data_t                mem_rev_data;
  logic                                  mem_rev_v;
  logic                                  mem_rev_ready_and;

  axil_mem_client u_client (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .lce_id_i            (lce_id_i),
    .did_i               (did_i),
    .mem_fwd_header_o    (mem_fwd_header),
    .mem_fwd_data_o      (mem_fwd_data),
    .mem_fwd_v_o         (mem_fwd_v),
    .mem_fwd_ready_and_i (mem_fwd_ready_and),
    .mem_rev_header_i    (mem_rev_header),
    .mem_rev_data_i      (mem_rev_data),
    .mem_rev_v_i         (mem_rev_v),
    .mem_rev_ready_and_o (mem_rev_ready_and),
    .s_axil_awaddr_i     (s_axil_awaddr_i),
    .s_axil_awprot_i     (s_axil_awprot_i),
    .s_axil_awvalid_i    (s_axil_awvalid_i),
    .s_axil_awready_o    (s_axil_awready_o),
    .s_axil_wdata_i      (s_axil_wdata_i),
    .s_axil_wstrb_i      (s_axil_wstrb_i),
    .s_axil_wvalid_i     (s_axil_wvalid_i),
    .s_axil_wready_o     (s_axil_wready_o),
    .s_axil_bresp_o      (s_axil_bresp_o),
    .s_axil_bvalid_o     (s_axil_bvalid_o),
    .s_axil_bready_i     (s_axil_bready_i),
    .s_axil_araddr_i     (s_axil_araddr_i),
    .s_axil_arprot_i     (s_axil_arprot_i),
    .s_axil_arvalid_i    (s_axil_arvalid_i),
    .s_axil_arready_o    (s_axil_arready_o),
    .s_axil_rdata_o      (s_axil_rdata_o),
    .s_axil_rresp_o      (s_axil_rresp_o),
    .s_axil_rvalid_o     (s_axil_rvalid_o),
    .s_axil_rready_i     (s_axil_rready_i)
  );

  mem_responder u_responder (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .mem_fwd_header_i    (mem_fwd_header),
    .mem_fwd_data_i      (mem_fwd_data),
    .mem_fwd_v_i         (mem_fwd_v),
    .mem_fwd_ready_and_o (mem_fwd_ready_and),
    .mem_rev_header_o    (mem_rev_header),
    .mem_rev_data_o      (mem_rev_data),
    .mem_rev_v_o         (mem_rev_v),
    .mem_rev_ready_and_i (mem_rev_ready_and)
  );

endmodule

`default_nettype wire

//--- verilog/mem_responder.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module mem_responder (
  input  wire                               clk_i,
  input  wire                               rst_i,

  input  wire mem_msg_pkg::mem_fwd_header_t mem_fwd_header_i,
  input  wire mem_msg_pkg::msg_data_t       mem_fwd_data_i,
  input  wire                               mem_fwd_v_i,
  output logic                              mem_fwd_ready_and_o,

  output mem_msg_pkg::mem_rev_header_t      mem_rev_header_o,
  output mem_msg_pkg::msg_data_t            mem_rev_data_o,
  output logic                              mem_rev_v_o,
  input  wire                               mem_rev_ready_and_i
);

  mem_msg_pkg::msg_data_t mem_q [`MEM_WORDS];

  logic [`MEM_IDX_W-1:0]     idx;
  logic [`AXIL_OFFSET_W-1:0] off;
  logic [`AXIL_MASK_W-1:0]   be;
  logic                      fwd_accept;
  logic                      rev_v_q;

  assign idx = mem_fwd_header_i.addr[`AXIL_OFFSET_W +: `MEM_IDX_W];
  assign off = mem_fwd_header_i.addr[`AXIL_OFFSET_W-1:0];

  // Byte lanes touched by a sized write
  always_comb begin
    case (mem_fwd_header_i.size)
      mem_msg_pkg::e_size_1: be = {{(`AXIL_MASK_W-1){1'b0}}, 1'b1} << off;
      mem_msg_pkg::e_size_2: be = {{(`AXIL_MASK_W-2){1'b0}}, 2'b11} << off;
      mem_msg_pkg::e_size_4: be = {{(`AXIL_MASK_W-4){1'b0}}, 4'hF} << off;
      default:               be = '1;
    endcase
  end

  // One reply outstanding at most
  assign mem_fwd_ready_and_o = !rev_v_q;
  assign fwd_accept          = mem_fwd_v_i && !rev_v_q;
  assign mem_rev_v_o         = rev_v_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rev_v_q <= 1'b0;
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (fwd_accept) begin
        rev_v_q <= 1'b1;
      end else if (mem_rev_ready_and_i) begin
        rev_v_q <= 1'b0;
      end
      if (fwd_accept && (mem_fwd_header_i.msg_type == mem_msg_pkg::e_mem_uc_wr)) begin
        for (int b = 0; b < `AXIL_MASK_W; b++) begin
          if (be[b]) begin
            mem_q[idx][8*b +: 8] <= mem_fwd_data_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Reply holds until taken
  always_ff @(posedge clk_i) begin
    if (fwd_accept) begin
      mem_rev_header_o <= mem_fwd_header_i;
      mem_rev_data_o   <= mem_q[idx];
    end
  end

endmodule

`default_nettype wire

//--- verilog/axil_mem_client.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module axil_mem_client (
  input  wire                            clk_i,
  input  wire                            rst_i,

  input  wire mem_msg_pkg::lce_id_t      lce_id_i,
  input  wire mem_msg_pkg::did_t         did_i,

  output mem_msg_pkg::mem_fwd_header_t   mem_fwd_header_o,
  output mem_msg_pkg::msg_data_t         mem_fwd_data_o,
  output logic                           mem_fwd_v_o,
  input  wire                            mem_fwd_ready_and_i,

  input  wire mem_msg_pkg::mem_rev_header_t mem_rev_header_i,
  input  wire mem_msg_pkg::msg_data_t    mem_rev_data_i,
  input  wire                            mem_rev_v_i,
  output logic                           mem_rev_ready_and_o,

  input  wire axil_pkg::axil_addr_t      s_axil_awaddr_i,
  input  wire [2:0]                      s_axil_awprot_i,
  input  wire                            s_axil_awvalid_i,
  output logic                           s_axil_awready_o,
  input  wire axil_pkg::axil_data_t      s_axil_wdata_i,
  input  wire axil_pkg::axil_strb_t      s_axil_wstrb_i,
  input  wire                            s_axil_wvalid_i,
  output logic                           s_axil_wready_o,
  output axil_pkg::axil_resp_t           s_axil_bresp_o,
  output logic                           s_axil_bvalid_o,
  input  wire                            s_axil_bready_i,
  input  wire axil_pkg::axil_addr_t      s_axil_araddr_i,
  input  wire [2:0]                      s_axil_arprot_i,
  input  wire                            s_axil_arvalid_i,
  output logic                           s_axil_arready_o,
  output axil_pkg::axil_data_t           s_axil_rdata_o,
  output axil_pkg::axil_resp_t           s_axil_rresp_o,
  output logic                           s_axil_rvalid_o,
  input  wire                            s_axil_rready_i
);

  axil_pkg::axil_data_t wdata_lo;
  axil_pkg::axil_addr_t addr_lo;
  axil_pkg::axil_strb_t wmask_lo;
  logic                 w_lo;
  logic                 v_lo;
  logic                 ready_and_lo;

  logic [`AXIL_OFFSET_W-1:0] low_byte;
  mem_msg_pkg::msg_size_e    size;

  axil_fifo_client fifo_client (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .data_o           (wdata_lo),
    .addr_o           (addr_lo),
    .w_o              (w_lo),
    .wmask_o          (wmask_lo),
    .v_o              (v_lo),
    .ready_and_i      (mem_fwd_ready_and_i),
    .data_i           (mem_rev_data_i),
    .v_i              (mem_rev_v_i),
    .ready_and_o      (ready_and_lo)
  );

  // Lowest strobed byte gives the start offset
  always_comb begin
    low_byte = '0;
    for (int i = `AXIL_MASK_W - 1; i >= 0; i--) begin
      if (wmask_lo[i]) begin
        low_byte = i[`AXIL_OFFSET_W-1:0];
      end
    end
  end

  // Aligned 1, 2 and 4 byte groups; anything else goes out full width
  always_comb begin
    size = mem_msg_pkg::e_size_8;
    if (w_lo) begin
      case (wmask_lo)
        8'h01, 8'h02, 8'h04, 8'h08,
        8'h10, 8'h20, 8'h40, 8'h80: size = mem_msg_pkg::e_size_1;
        8'h03, 8'h0C, 8'h30, 8'hC0: size = mem_msg_pkg::e_size_2;
        8'h0F, 8'hF0:               size = mem_msg_pkg::e_size_4;
        default:                    size = mem_msg_pkg::e_size_8;
      endcase
    end
  end

  always_comb begin
    mem_fwd_header_o          = '0;
    mem_fwd_header_o.msg_type = w_lo ? mem_msg_pkg::e_mem_uc_wr : mem_msg_pkg::e_mem_uc_rd;
    mem_fwd_header_o.size     = size;
    mem_fwd_header_o.lce_id   = lce_id_i;
    mem_fwd_header_o.did      = did_i;
    mem_fwd_header_o.addr     = {addr_lo[`AXIL_ADDR_W-1:`AXIL_OFFSET_W],
                                 (size == mem_msg_pkg::e_size_8) ? '0 : low_byte};
  end

  assign mem_fwd_data_o      = wdata_lo;
  assign mem_fwd_v_o         = v_lo;
  assign mem_rev_ready_and_o = ready_and_lo;

endmodule

`default_nettype wire

//--- verilog/axil_fifo_client.sv
`timescale 1ns/1ps
`default_nettype none

module axil_fifo_client (
  input  wire                  clk_i,
  input  wire                  rst_i,

  input  wire axil_pkg::axil_addr_t s_axil_awaddr_i,
  input  wire [2:0]                 s_axil_awprot_i,
  input  wire                       s_axil_awvalid_i,
  output logic                      s_axil_awready_o,

  input  wire axil_pkg::axil_data_t s_axil_wdata_i,
  input  wire axil_pkg::axil_strb_t s_axil_wstrb_i,
  input  wire                       s_axil_wvalid_i,
  output logic                      s_axil_wready_o,

  output axil_pkg::axil_resp_t      s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  wire                       s_axil_bready_i,

  input  wire axil_pkg::axil_addr_t s_axil_araddr_i,
  input  wire [2:0]                 s_axil_arprot_i,
  input  wire                       s_axil_arvalid_i,
  output logic                      s_axil_arready_o,

  output axil_pkg::axil_data_t      s_axil_rdata_o,
  output axil_pkg::axil_resp_t      s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  wire                       s_axil_rready_i,

  output axil_pkg::axil_data_t      data_o,
  output axil_pkg::axil_addr_t      addr_o,
  output logic                      w_o,
  output axil_pkg::axil_strb_t      wmask_o,
  output logic                      v_o,
  input  wire                       ready_and_i,

  input  wire axil_pkg::axil_data_t data_i,
  input  wire                       v_i,
  output logic                      ready_and_o
);

  axil_pkg::fifo_state_e state_q, state_d;

  logic                 w_q;
  axil_pkg::axil_addr_t addr_q;
  axil_pkg::axil_data_t wdata_q;
  axil_pkg::axil_strb_t wmask_q;
  axil_pkg::axil_data_t rdata_q;

  logic write_accept;
  logic read_accept;
  logic resp_done;

  // Address and data of a write are taken in the same cycle
  assign write_accept = (state_q == axil_pkg::e_fifo_idle)
                        && s_axil_awvalid_i && s_axil_wvalid_i;
  // Any sign of a write holds the read back
  assign read_accept  = (state_q == axil_pkg::e_fifo_idle) && s_axil_arvalid_i
                        && !s_axil_awvalid_i && !s_axil_wvalid_i;

  assign resp_done = (state_q == axil_pkg::e_fifo_respond)
                     && (w_q ? s_axil_bready_i : s_axil_rready_i);

  assign s_axil_awready_o = write_accept;
  assign s_axil_wready_o  = write_accept;
  assign s_axil_arready_o = read_accept;

  // Request side
  assign v_o     = (state_q == axil_pkg::e_fifo_request);
  assign w_o     = w_q;
  assign addr_o  = addr_q;
  assign data_o  = wdata_q;
  assign wmask_o = wmask_q;

  // Response side
  assign ready_and_o     = (state_q == axil_pkg::e_fifo_wait_resp);
  assign s_axil_bvalid_o = (state_q == axil_pkg::e_fifo_respond) && w_q;
  assign s_axil_rvalid_o = (state_q == axil_pkg::e_fifo_respond) && !w_q;
  assign s_axil_rdata_o  = rdata_q;
  assign s_axil_bresp_o  = 2'b00;
  assign s_axil_rresp_o  = 2'b00;

  always_comb begin
    state_d = state_q;
    case (state_q)
      axil_pkg::e_fifo_idle: begin
        if (write_accept || read_accept) begin
          state_d = axil_pkg::e_fifo_request;
        end
      end
      axil_pkg::e_fifo_request: begin
        if (ready_and_i) begin
          state_d = axil_pkg::e_fifo_wait_resp;
        end
      end
      axil_pkg::e_fifo_wait_resp: begin
        if (v_i) begin
          state_d = axil_pkg::e_fifo_respond;
        end
      end
      default: begin
        if (resp_done) begin
          state_d = axil_pkg::e_fifo_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= axil_pkg::e_fifo_idle;
      w_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (write_accept) begin
        w_q <= 1'b1;
      end else if (read_accept) begin
        w_q <= 1'b0;
      end
    end
  end

  // Captured request and returned word
  always_ff @(posedge clk_i) begin
    if (write_accept) begin
      addr_q  <= s_axil_awaddr_i;
      wdata_q <= s_axil_wdata_i;
      wmask_q <= s_axil_wstrb_i;
    end else if (read_accept) begin
      addr_q <= s_axil_araddr_i;
    end
    if (ready_and_o && v_i) begin
      rdata_q <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_msg_pkg.sv
`default_nettype none

`include "bridge_consts.svh"

package mem_msg_pkg;

  typedef logic [`AXIL_DATA_W-1:0] msg_data_t;
  typedef logic [`AXIL_ADDR_W-1:0] msg_addr_t;
  typedef logic [`LCE_ID_W-1:0]    lce_id_t;
  typedef logic [`DID_W-1:0]       did_t;

  // Uncached message codes
  typedef enum logic [3:0] {
    e_mem_uc_rd = 4'b0000,
    e_mem_uc_wr = 4'b0001
  } msg_type_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    e_size_1 = 3'd0,
    e_size_2 = 3'd1,
    e_size_4 = 3'd2,
    e_size_8 = 3'd3
  } msg_size_e;

  typedef struct packed {
    msg_type_e msg_type;
    msg_size_e size;
    msg_addr_t addr;
    lce_id_t   lce_id;
    did_t      did;
  } mem_fwd_header_t;

  // Replies carry the request header back unchanged
  typedef mem_fwd_header_t mem_rev_header_t;

  localparam int MSG_FWD_HDR_W = $bits(mem_fwd_header_t);

endpackage

`default_nettype wire

//--- verilog/axil_pkg.sv
`default_nettype none

`include "bridge_consts.svh"

package axil_pkg;

  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_MASK_W-1:0] axil_strb_t;
  typedef logic [1:0]              axil_resp_t;

  // Front end walks one transaction through these states
  typedef enum logic [1:0] {
    e_fifo_idle      = 2'd0,
    e_fifo_request   = 2'd1,
    e_fifo_wait_resp = 2'd2,
    e_fifo_respond   = 2'd3
  } fifo_state_e;

endpackage

`default_nettype wire

//--- verilog/bridge_consts.svh
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// AXI-Lite data path and memory message data
`define AXIL_DATA_W 64

// Byte address
`define AXIL_ADDR_W 16

// One strobe bit per data byte
`define AXIL_MASK_W 8

// Byte offset inside a data word
`define AXIL_OFFSET_W 3

// Header payload identifiers
`define LCE_ID_W 4
`define DID_W 3

// Responder storage
`define MEM_WORDS 64
`define MEM_IDX_W 6

`endif
